// ==== Makefile ====
TOP  := mesh_with_controller_tb
SRCS := $(shell cat mesh_with_controller.f)

obj_dir/V$(TOP): mesh_with_controller.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f mesh_with_controller.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== mesh_with_controller.f ====
src/snn_pkg.sv
src/spike_controller.sv
src/neuron_core.sv
src/spike_router.sv
src/mesh_with_controller.sv
tb/mesh_with_controller_tb.sv

// ==== src/mesh_with_controller.sv ====
/* Neural tile top */
`timescale 1ns/1ps

module mesh_with_controller
  import snn_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  host_event_t in_event,
  input  logic        out_credit,
  output logic        in_credit,
  output logic        out_valid,
  output spike_pkt_t  out_pkt,
  output step_t       step_count
);

  logic       c2r_valid;
  spike_pkt_t c2r_pkt;
  logic       c2r_credit;
  logic       r2n_valid;
  spike_pkt_t r2n_pkt;
  logic       r2n_credit;
  logic       n2r_valid;
  spike_pkt_t n2r_pkt;
  logic       n2r_credit;
  logic       step_done_seen;

  assign step_done_seen = out_valid && (out_pkt.kind == PKT_STEP_DONE);  // Step left the tile

  spike_controller spike_controller_inst (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_event       (in_event),
    .c2r_credit     (c2r_credit),
    .step_done_seen (step_done_seen),
    .in_credit      (in_credit),
    .c2r_valid      (c2r_valid),
    .c2r_pkt        (c2r_pkt),
    .step_count     (step_count)
  );

  spike_router spike_router_inst (
    .clk        (clk),
    .rst        (rst),
    .c2r_valid  (c2r_valid),
    .c2r_pkt    (c2r_pkt),
    .r2n_credit (r2n_credit),
    .n2r_valid  (n2r_valid),
    .n2r_pkt    (n2r_pkt),
    .out_credit (out_credit),
    .c2r_credit (c2r_credit),
    .r2n_valid  (r2n_valid),
    .r2n_pkt    (r2n_pkt),
    .n2r_credit (n2r_credit),
    .out_valid  (out_valid),
    .out_pkt    (out_pkt)
  );

  neuron_core neuron_core_inst (
    .clk        (clk),
    .rst        (rst),
    .r2n_valid  (r2n_valid),
    .r2n_pkt    (r2n_pkt),
    .n2r_credit (n2r_credit),
    .r2n_credit (r2n_credit),
    .n2r_valid  (n2r_valid),
    .n2r_pkt    (n2r_pkt)
  );

endmodule

// ==== src/neuron_core.sv ====
/* Integrate-and-fire core */
`timescale 1ns/1ps

module neuron_core
  import snn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       r2n_valid,
  input  spike_pkt_t r2n_pkt,
  input  logic       n2r_credit,
  output logic       r2n_credit,
  output logic       n2r_valid,
  output spike_pkt_t n2r_pkt
);

  typedef enum logic [1:0] {
    ST_INTEGRATE,
    ST_FIRE,
    ST_DONE
  } state_t;

  spike_pkt_t fifo_mem [FIFO_DEPTH];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  spike_pkt_t head;
  logic       fifo_empty;
  logic       pop;
  credit_t    credit;
  logic       can_send;
  state_t     state;
  neuron_id_t fire_idx;
  step_t      cur_step;
  potential_t pot [NUM_NEURONS];
  logic       fires;
  logic       advance;
  logic       send_spike;
  logic       send_done;

  function automatic potential_t sat_add(potential_t p, weight_t w);
    logic signed [8:0] sum;
    potential_t        res;
    sum = p + w;
    if (sum > POT_MAX) begin
      res = POT_MAX;
    end else if (sum < POT_MIN) begin
      res = POT_MIN;
    end else begin
      res = potential_t'(sum);
    end
    return res;
  endfunction

  // Move toward zero without crossing it
  function automatic potential_t leak_step(potential_t p);
    potential_t res;
    res = '0;
    if (p > LEAK) begin
      res = p - LEAK;
    end else if (p < -LEAK) begin
      res = p + LEAK;
    end
    return res;
  endfunction

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign head       = fifo_mem[rd_ptr[PTR_W-1:0]];
  assign pop        = (state == ST_INTEGRATE) && !fifo_empty;
  assign can_send   = (credit != '0);
  assign fires      = (pot[fire_idx] >= THRESHOLD);
  assign advance    = (state == ST_FIRE) && (!fires || can_send);  // Only a spike needs credit
  assign send_spike = (state == ST_FIRE) && fires && can_send;
  assign send_done  = (state == ST_DONE) && can_send;

  ////////////////////////////////////////////////////////////
  // Input FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (r2n_valid) begin
      fifo_mem[wr_ptr[PTR_W-1:0]] <= r2n_pkt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      r2n_credit <= 1'b0;
    end else begin
      if (r2n_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      r2n_credit <= pop;
    end
  end

  ////////////////////////////////////////////////////////////
  // Membrane potentials and step FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < NUM_NEURONS; n++) begin
        pot[n] <= '0;
      end
    end else if (pop && head.kind == PKT_AXON) begin
      for (int n = 0; n < NUM_NEURONS; n++) begin
        pot[n] <= sat_add(pot[n], WEIGHTS[head.id][n]);     // Whole weight row at once
      end
    end else if (advance) begin
      pot[fire_idx] <= fires ? '0 : leak_step(pot[fire_idx]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_INTEGRATE;
      fire_idx <= '0;
    end else begin
      case (state)
        ST_INTEGRATE: begin
          if (pop && head.kind == PKT_STEP_END) begin
            state    <= ST_FIRE;
            fire_idx <= '0;
          end
        end
        ST_FIRE: begin
          if (advance) begin
            if (fire_idx == neuron_id_t'(NUM_NEURONS - 1)) begin
              state <= ST_DONE;
            end
            fire_idx <= fire_idx + 1'b1;
          end
        end
        ST_DONE: begin
          if (can_send) begin
            state <= ST_INTEGRATE;
          end
        end
        default: state <= ST_INTEGRATE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop && head.kind == PKT_STEP_END) begin
      cur_step <= head.step;
    end
  end

  // Spike and step-done output
  always_ff @(posedge clk) begin
    if (rst) begin
      credit    <= credit_t'(FIFO_DEPTH);
      n2r_valid <= 1'b0;
    end else begin
      credit    <= credit - credit_t'(send_spike || send_done) + credit_t'(n2r_credit);
      n2r_valid <= send_spike || send_done;
    end
  end

  always_ff @(posedge clk) begin
    if (send_spike) begin
      n2r_pkt.kind <= PKT_SPIKE;
      n2r_pkt.step <= cur_step;
      n2r_pkt.id   <= fire_idx;
    end else if (send_done) begin
      n2r_pkt.kind <= PKT_STEP_DONE;
      n2r_pkt.step <= cur_step;
      n2r_pkt.id   <= '0;
    end
  end

endmodule

// ==== src/snn_pkg.sv ====
/* Spiking tile definitions */
package snn_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int NUM_NEURONS    = 4;
  localparam int NUM_AXONS      = 4;
  localparam int FIFO_DEPTH     = 4;                        // Also the initial credit count
  localparam int PTR_W          = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W       = $clog2(FIFO_DEPTH + 1);
  localparam int ROUTE_CHANNELS = 2;                        // Controller to core, core to output

  typedef logic [$clog2(NUM_AXONS)-1:0]   axon_id_t;
  typedef logic [$clog2(NUM_NEURONS)-1:0] neuron_id_t;
  typedef logic [7:0]                     step_t;           // Wraps
  typedef logic signed [7:0]              potential_t;
  typedef logic signed [5:0]              weight_t;
  typedef logic [CREDIT_W-1:0]            credit_t;
  typedef logic [PTR_W:0]                 ptr_t;            // Extra bit tells full from empty

  ////////////////////////////////////////////////////////////
  // Neuron model
  ////////////////////////////////////////////////////////////

  localparam potential_t THRESHOLD = 8'sd16;
  localparam potential_t LEAK      = 8'sd1;
  localparam potential_t POT_MAX   = 8'sd127;
  localparam potential_t POT_MIN   = -8'sd128;

  // Row is the axon, column the neuron
  localparam weight_t [0:NUM_AXONS-1][0:NUM_NEURONS-1] WEIGHTS = '{
    '{ 6'sd3,   6'sd5,  -6'sd2,   6'sd1 },
    '{ 6'sd8,  -6'sd4,   6'sd6,   6'sd2 },
    '{-6'sd6,   6'sd9,   6'sd4,  -6'sd8 },
    '{ 6'sd12,  6'sd2,  -6'sd10,  6'sd17}
  };

  ////////////////////////////////////////////////////////////
  // Packets
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PKT_AXON,
    PKT_STEP_END,
    PKT_SPIKE,
    PKT_STEP_DONE
  } pkt_kind_t;

  typedef struct packed {
    pkt_kind_t  kind;
    step_t      step;
    neuron_id_t id;                                         // Axon index on axon packets
  } spike_pkt_t;

  typedef struct packed {
    axon_id_t axon;
    logic     last;                                         // Closes the time step
  } host_event_t;

endpackage

// ==== src/spike_controller.sv ====
/* Time-step controller */
`timescale 1ns/1ps

module spike_controller
  import snn_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  host_event_t in_event,
  input  logic        c2r_credit,
  input  logic        step_done_seen,
  output logic        in_credit,
  output logic        c2r_valid,
  output spike_pkt_t  c2r_pkt,
  output step_t       step_count
);

  typedef enum logic [1:0] {
    ST_FWD,
    ST_STEP_END,
    ST_WAIT_DONE
  } state_t;

  host_event_t fifo_mem [FIFO_DEPTH];
  ptr_t        wr_ptr;
  ptr_t        rd_ptr;
  host_event_t head;
  logic        fifo_empty;
  credit_t     credit;
  logic        can_send;
  logic        pop;
  logic        send_end;
  logic        send;
  state_t      state;

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign head       = fifo_mem[rd_ptr[PTR_W-1:0]];
  assign can_send   = (credit != '0);
  assign pop        = (state == ST_FWD) && !fifo_empty && can_send;
  assign send_end   = (state == ST_STEP_END) && can_send;
  assign send       = pop || send_end;

  ////////////////////////////////////////////////////////////
  // Host FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_valid) begin
      fifo_mem[wr_ptr[PTR_W-1:0]] <= in_event;              // Host holds a credit for this
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      in_credit <= pop;                                     // One credit back per pop
    end
  end

  ////////////////////////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_FWD;
      step_count <= '0;
    end else begin
      case (state)
        ST_FWD: begin
          if (pop && head.last) begin
            state <= ST_STEP_END;
          end
        end
        ST_STEP_END: begin
          if (can_send) begin
            state <= ST_WAIT_DONE;
          end
        end
        ST_WAIT_DONE: begin
          if (step_done_seen) begin                         // Core finished the step
            state      <= ST_FWD;
            step_count <= step_count + 1'b1;
          end
        end
        default: state <= ST_FWD;
      endcase
    end
  end

  // Outbound credit and packet
  always_ff @(posedge clk) begin
    if (rst) begin
      credit    <= credit_t'(FIFO_DEPTH);
      c2r_valid <= 1'b0;
    end else begin
      credit    <= credit - credit_t'(send) + credit_t'(c2r_credit);
      c2r_valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      c2r_pkt.kind <= PKT_AXON;
      c2r_pkt.step <= step_count;
      c2r_pkt.id   <= head.axon;
    end else if (send_end) begin
      c2r_pkt.kind <= PKT_STEP_END;
      c2r_pkt.step <= step_count;
      c2r_pkt.id   <= '0;
    end
  end

endmodule

// ==== src/spike_router.sv ====
/* Boundary packet router */
`timescale 1ns/1ps

module spike_router
  import snn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       c2r_valid,
  input  spike_pkt_t c2r_pkt,
  input  logic       r2n_credit,
  input  logic       n2r_valid,
  input  spike_pkt_t n2r_pkt,
  input  logic       out_credit,
  output logic       c2r_credit,
  output logic       r2n_valid,
  output spike_pkt_t r2n_pkt,
  output logic       n2r_credit,
  output logic       out_valid,
  output spike_pkt_t out_pkt
);

  // Channel 0 runs controller to core, channel 1 core to output
  logic       ch_in_valid  [ROUTE_CHANNELS];
  spike_pkt_t ch_in_pkt    [ROUTE_CHANNELS];
  logic       ch_dn_credit [ROUTE_CHANNELS];
  logic       ch_up_credit [ROUTE_CHANNELS];
  logic       ch_out_valid [ROUTE_CHANNELS];
  spike_pkt_t ch_out_pkt   [ROUTE_CHANNELS];

  assign ch_in_valid[0]  = c2r_valid;
  assign ch_in_pkt[0]    = c2r_pkt;
  assign ch_dn_credit[0] = r2n_credit;
  assign ch_in_valid[1]  = n2r_valid;
  assign ch_in_pkt[1]    = n2r_pkt;
  assign ch_dn_credit[1] = out_credit;

  assign c2r_credit = ch_up_credit[0];
  assign r2n_valid  = ch_out_valid[0];
  assign r2n_pkt    = ch_out_pkt[0];
  assign n2r_credit = ch_up_credit[1];
  assign out_valid  = ch_out_valid[1];
  assign out_pkt    = ch_out_pkt[1];

  ////////////////////////////////////////////////////////////
  // Credit-managed FIFO per channel
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < ROUTE_CHANNELS; ch++) begin : g_ch
    spike_pkt_t mem [FIFO_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    credit_t    credit;
    logic       pop;
    logic       up_credit_q;
    logic       valid_q;
    spike_pkt_t pkt_q;

    // Forward only with a downstream slot in hand
    assign pop = (wr_ptr != rd_ptr) && (credit != '0);

    always_ff @(posedge clk) begin
      if (ch_in_valid[ch]) begin
        mem[wr_ptr[PTR_W-1:0]] <= ch_in_pkt[ch];
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        wr_ptr      <= '0;
        rd_ptr      <= '0;
        credit      <= credit_t'(FIFO_DEPTH);
        up_credit_q <= 1'b0;
        valid_q     <= 1'b0;
      end else begin
        if (ch_in_valid[ch]) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        credit      <= credit - credit_t'(pop) + credit_t'(ch_dn_credit[ch]);
        up_credit_q <= pop;                                 // Slot freed upstream
        valid_q     <= pop;
      end
    end

    always_ff @(posedge clk) begin
      if (pop) begin
        pkt_q <= mem[rd_ptr[PTR_W-1:0]];
      end
    end

    assign ch_up_credit[ch] = up_credit_q;
    assign ch_out_valid[ch] = valid_q;
    assign ch_out_pkt[ch]   = pkt_q;
  end

endmodule

// ==== tb/mesh_with_controller_tb.sv ====
/* Neural tile testbench */
`timescale 1ns/1ps

module mesh_with_controller_tb
  import snn_pkg::*;
();

  localparam int NUM_ROWS       = 9;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int HOLD_CYCLES    = 60;

  typedef struct packed {
    logic [5:0]  len;
    logic [63:0] axons;                                     // Event k in bits 2k+1:2k
    logic [3:0]  mask;                                      // Bit n set when neuron n fires
  } row_t;

  // Each row is one time step
  localparam row_t ROWS [NUM_ROWS] = '{
    '{6'd1,  64'h0000_0000_0000_0000, 4'b0000},             // Below threshold
    '{6'd2,  64'h0000_0000_0000_0005, 4'b0001},
    '{6'd2,  64'h0000_0000_0000_0007, 4'b1001},
    '{6'd1,  64'h0000_0000_0000_0000, 4'b0000},             // Mostly leak
    '{6'd1,  64'h0000_0000_0000_0000, 4'b0000},
    '{6'd9,  64'h0000_0000_0003_ea55, 4'b1111},             // Sent under back-pressure
    '{6'd13, 64'h0000_0000_03ff_ffff, 4'b1011},             // Clamps at both limits
    '{6'd24, 64'h0000_5555_5555_5555, 4'b1101},
    '{6'd13, 64'h0000_0000_02aa_aaaa, 4'b0110}
  };

  logic        clk;
  logic        rst;
  logic        in_valid;
  host_event_t in_event;
  logic        out_credit = 1'b0;
  logic        in_credit;
  logic        out_valid;
  spike_pkt_t  out_pkt;
  step_t       step_count;

  int          seed            = 32'hf451_a6cc;
  int          sent_count      = 0;                         // Events driven on the host link
  int          credits_back    = 0;
  int          rx_count        = 0;
  int          credits_given   = 0;
  int          rx_at_hold      = 0;
  logic        hold            = 1'b0;                      // Withholds out_credit
  spike_pkt_t  exp_q [$];
  int          model_pot [NUM_NEURONS];
  logic [3:0]  step_mask       = '0;
  logic        count_pending   = 1'b0;
  step_t       want_count      = '0;
  int          count_wait      = 0;
  int          mismatch_errors = 0;
  int          timeout_errors  = 0;
  int          protocol_errors = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  mesh_with_controller mesh_with_controller_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_event   (in_event),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_pkt    (out_pkt),
    .step_count (step_count)
  );

  ////////////////////////////////////////////////////////////
  // Reference neuron model
  ////////////////////////////////////////////////////////////

  function automatic int clamp_add(int pot, int w);
    int s;
    s = pot + w;
    if (s > 127) begin
      s = 127;
    end else if (s < -128) begin
      s = -128;
    end
    return s;
  endfunction

  task automatic predict_step(input int r);
    axon_id_t   a;
    spike_pkt_t p;
    for (int k = 0; k < int'(ROWS[r].len); k++) begin
      a = ROWS[r].axons[2*k +: 2];
      for (int n = 0; n < NUM_NEURONS; n++) begin
        model_pot[n] = clamp_add(model_pot[n], int'(WEIGHTS[a][n]));
      end
    end
    p.step = step_t'(r);
    for (int n = 0; n < NUM_NEURONS; n++) begin
      if (model_pot[n] >= int'(THRESHOLD)) begin
        p.kind = PKT_SPIKE;
        p.id   = neuron_id_t'(n);
        exp_q.push_back(p);
        model_pot[n] = 0;
      end else if (model_pot[n] > 0) begin
        model_pot[n] = model_pot[n] - int'(LEAK);
      end else if (model_pot[n] < 0) begin
        model_pot[n] = model_pot[n] + int'(LEAK);
      end
    end
    p.kind = PKT_STEP_DONE;
    p.id   = '0;
    exp_q.push_back(p);
  endtask

  ////////////////////////////////////////////////////////////
  // Host side and output sink
  ////////////////////////////////////////////////////////////

  task automatic send_row(input int r);
    int k;
    int t;
    k = 0;
    t = 0;
    while (k < int'(ROWS[r].len) && t <= TIMEOUT_CYCLES) begin
      @(posedge clk);
      if (sent_count - credits_back < FIFO_DEPTH) begin
        in_valid <= 1'b1;
        in_event <= '{axon: ROWS[r].axons[2*k +: 2], last: (k == int'(ROWS[r].len) - 1)};
        sent_count++;
        k++;
        t = 0;
      end else begin
        in_valid <= 1'b0;                                   // No host credit left
        t++;
      end
    end
    if (k < int'(ROWS[r].len)) begin
      $display("timeout waiting for a host credit in row %0d", r);
      timeout_errors++;
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      out_credit <= 1'b0;
    end else if (!hold && credits_given < rx_count && ($random(seed) & 3) == 0) begin
      out_credit    <= 1'b1;
      credits_given <= credits_given + 1;
    end else begin
      out_credit <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  task automatic check_packet();
    spike_pkt_t exp;
    if (exp_q.size() == 0) begin
      $display("unexpected packet %h on out_pkt at %0t", out_pkt, $time);
      protocol_errors++;
    end else begin
      exp = exp_q.pop_front();
      if (out_pkt !== exp) begin
        $display("mismatch at %0t: out_pkt expected %h, got %h", $time, exp, out_pkt);
        mismatch_errors++;
      end
    end
    if (out_pkt.kind == PKT_SPIKE) begin
      step_mask[out_pkt.id] = 1'b1;
    end else if (out_pkt.kind == PKT_STEP_DONE) begin
      if (step_mask !== ROWS[want_count].mask) begin
        $display("mismatch at %0t: spike mask of step %0d expected %b, got %b",
                 $time, want_count, ROWS[want_count].mask, step_mask);
        mismatch_errors++;
      end
      step_mask     = '0;
      want_count    = want_count + 1'b1;
      count_wait    = 0;
      count_pending = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      if (count_pending) begin
        if (step_count == want_count) begin
          count_pending = 1'b0;
        end else if (count_wait >= TIMEOUT_CYCLES) begin
          $display("timeout waiting for step_count to reach %0d", want_count);
          timeout_errors++;
          count_pending = 1'b0;
        end else begin
          count_wait++;
        end
      end
      if (in_credit) begin
        credits_back++;
        if (credits_back > sent_count) begin
          $display("host credit returned at %0t with no event outstanding", $time);
          protocol_errors++;
        end
      end
      if (out_valid) begin
        rx_count++;
        check_packet();
      end
    end
  end

  task automatic check_idle();
    if (out_valid !== 1'b0 || in_credit !== 1'b0 || step_count !== '0) begin
      $display("mismatch at %0t: out_valid/in_credit/step_count expected 0/0/0, got %b/%b/%0d",
               $time, out_valid, in_credit, step_count);
      mismatch_errors++;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_q.size() != 0 || count_pending || credits_given != rx_count)
           && t < TIMEOUT_CYCLES) begin
      @(posedge clk);
      t++;
    end
    if (exp_q.size() != 0 || count_pending || credits_given != rx_count) begin
      $display("timeout with %0d packets still expected", exp_q.size());
      timeout_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_event = '0;
    for (int n = 0; n < NUM_NEURONS; n++) begin
      model_pot[n] = 0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_idle();
    end

    for (int r = 0; r < 5; r++) begin
      predict_step(r);
      send_row(r);
    end
    wait_drain();

    // Step 5 with out_credit withheld
    hold       <= 1'b1;
    rx_at_hold = rx_count;
    predict_step(5);
    send_row(5);
    repeat (HOLD_CYCLES) @(posedge clk);
    if (rx_count - rx_at_hold > FIFO_DEPTH) begin
      $display("%0d packets left the tile without credit", rx_count - rx_at_hold);
      protocol_errors++;
    end
    if (exp_q.size() == 0) begin
      $display("step 5 completed although out_credit was withheld");
      protocol_errors++;
    end
    hold <= 1'b0;

    // Burst sent while step 5 is still pending
    for (int r = 6; r < NUM_ROWS; r++) begin
      predict_step(r);
      send_row(r);
    end
    wait_drain();
    if (step_count !== step_t'(NUM_ROWS)) begin
      $display("mismatch at %0t: step_count expected %0d, got %0d", $time, NUM_ROWS, step_count);
      mismatch_errors++;
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d protocol",
             mismatch_errors, timeout_errors, protocol_errors);
    if (mismatch_errors + timeout_errors + protocol_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
